// ==== line_encoder_top.f ====
source/line_code_pkg.sv
source/enc_5b6b.sv
source/enc_3b4b.sv
source/disparity_merge.sv
source/wb_symbol_port.sv
source/line_encoder_top.sv
tb/tb_clock.sv
tb/tb_line_encoder.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the line encoder testbench with Verilator, run it, scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -Wno-fatal --top-module tb_line_encoder \
	-f line_encoder_top.f -o tb_line_encoder \
	&& ./obj_dir/tb_line_encoder > sim.log 2>&1 \
	|| { echo "Build or simulation did not complete"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "\*\* FAIL \*\*" sim.log && { echo "Simulation failed"; exit 1; }
echo "Simulation passed"
exit 0

// ==== source/disparity_merge.sv ====
//--------------------------------------------------------------------------
// Code group and RD update only on advance; both reset to zero, RD negative
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module disparity_merge
(
	input  logic                           clk,
	input  logic                           nreset,
	input  logic                           advance,
	input  logic                           k,
	input  logic                           y_is7,
	input  logic [5:0]                     code6_neg,
	input  logic                           neutral6,
	input  logic                           alt_neg_hint,
	input  logic                           alt_pos_hint,
	input  logic [3:0]                     code4_neg,
	input  logic [3:0]                     code4_alt_neg,
	input  logic                           neutral4,
	output logic [line_code_pkg::CODE_W-1:0] code_group,
	output logic                           rd_out
);

	logic       rd_q;
	logic [5:0] code6;
	logic       rd_mid;
	logic       use_alt;
	logic [3:0] code4_sel;
	logic [3:0] code4;
	logic       rd_next;

	always_comb
	begin
		// 6b part against the running disparity
		code6  = (rd_q && !neutral6) ? ~code6_neg : code6_neg;
		rd_mid = ($countones(code6_neg) == 3) ? rd_q : ~rd_q;

		// A7 for control .7 and for the data cases that would run five
		use_alt   = y_is7 && (k || (rd_mid ? alt_pos_hint : alt_neg_hint));
		code4_sel = use_alt ? code4_alt_neg : code4_neg;

		// 4b part against the disparity left by the 6b part
		code4   = (rd_mid && !neutral4) ? ~code4_sel : code4_sel;
		rd_next = ($countones(code4_sel) == 2) ? rd_mid : ~rd_mid;
	end

	//----------------------------------------------------------------------
	// Symbol slot register
	//----------------------------------------------------------------------
	always_ff @(posedge clk or negedge nreset)
	begin
		if (!nreset)
		begin
			code_group <= '0;
			rd_q       <= 1'b0;
		end
		else if (advance)
		begin
			// a lands in bit 9, j in bit 0
			code_group <= {code6, code4};
			rd_q       <= rd_next;
		end
	end

	assign rd_out = rd_q;

endmodule

// ==== source/enc_3b4b.sv ====
//--------------------------------------------------------------------------
// RD-minus forms only; K forms assume the port passed a legal control set
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module enc_3b4b
(
	input  logic       k,
	input  logic [2:0] y3,
	output logic [3:0] code4_neg,
	output logic [3:0] code4_alt_neg,
	output logic       neutral4
);

	logic k_flip;

	// K28.1, .2, .5 and .6 use the opposite balanced form
	assign k_flip = k && ((y3 == 3'd1) || (y3 == 3'd2) || (y3 == 3'd5) || (y3 == 3'd6));

	// HGF to fghj, f in bit 3
	always_comb
	begin
		neutral4 = 1'b0;
		case (y3)
			3'd0:    code4_neg = 4'b1011;
			3'd1:
			begin
				code4_neg = 4'b1001;
				neutral4  = 1'b1;
			end
			3'd2:
			begin
				code4_neg = 4'b0101;
				neutral4  = 1'b1;
			end
			3'd3:    code4_neg = 4'b1100;
			3'd4:    code4_neg = 4'b1101;
			3'd5:
			begin
				code4_neg = 4'b1010;
				neutral4  = 1'b1;
			end
			3'd6:
			begin
				code4_neg = 4'b0110;
				neutral4  = 1'b1;
			end
			default: code4_neg = 4'b1110;
		endcase
		if (k_flip)
		begin
			code4_neg = ~code4_neg;
			neutral4  = 1'b0;
		end
	end

	// A7 only exists for y = 7
	assign code4_alt_neg = (y3 == 3'd7) ? 4'b0111 : code4_neg;

endmodule

// ==== source/enc_5b6b.sv ====
//--------------------------------------------------------------------------
// Purely combinational, RD-minus form only; the merge does the complement
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module enc_5b6b
(
	input  logic       k,
	input  logic [4:0] x5,
	output logic [5:0] code6_neg,
	output logic       neutral6,
	output logic       alt_neg_hint,
	output logic       alt_pos_hint
);

	// EDCBA to abcdei, a in bit 5
	always_comb
	begin
		case (x5)
			5'd0:    code6_neg = 6'b100111;
			5'd1:    code6_neg = 6'b011101;
			5'd2:    code6_neg = 6'b101101;
			5'd3:    code6_neg = 6'b110001;
			5'd4:    code6_neg = 6'b110101;
			5'd5:    code6_neg = 6'b101001;
			5'd6:    code6_neg = 6'b011001;
			5'd7:    code6_neg = 6'b111000;
			5'd8:    code6_neg = 6'b111001;
			5'd9:    code6_neg = 6'b100101;
			5'd10:   code6_neg = 6'b010101;
			5'd11:   code6_neg = 6'b110100;
			5'd12:   code6_neg = 6'b001101;
			5'd13:   code6_neg = 6'b101100;
			5'd14:   code6_neg = 6'b011100;
			5'd15:   code6_neg = 6'b010111;
			5'd16:   code6_neg = 6'b011011;
			5'd17:   code6_neg = 6'b100011;
			5'd18:   code6_neg = 6'b010011;
			5'd19:   code6_neg = 6'b110010;
			5'd20:   code6_neg = 6'b001011;
			5'd21:   code6_neg = 6'b101010;
			5'd22:   code6_neg = 6'b011010;
			5'd23:   code6_neg = 6'b111010;
			5'd24:   code6_neg = 6'b110011;
			5'd25:   code6_neg = 6'b100110;
			5'd26:   code6_neg = 6'b010110;
			5'd27:   code6_neg = 6'b110110;
			5'd28:   code6_neg = k ? 6'b001111 : 6'b001110;
			5'd29:   code6_neg = 6'b101110;
			5'd30:   code6_neg = 6'b011110;
			default: code6_neg = 6'b101011;
		endcase
	end

	// D.07 is balanced but still alternates with disparity
	assign neutral6 = ($countones(code6_neg) == 3) && (x5 != 5'd7);

	// x values whose .7 form would give a run of five, per disparity
	assign alt_neg_hint = (x5 == 5'd17) || (x5 == 5'd18) || (x5 == 5'd20);
	assign alt_pos_hint = (x5 == 5'd11) || (x5 == 5'd13) || (x5 == 5'd14);

endmodule

// ==== source/line_code_pkg.sv ====
//--------------------------------------------------------------------------
// Widths are fixed by the 8b/10b line code and the 16-bit Wishbone port
//--------------------------------------------------------------------------

package line_code_pkg;

	// Line code widths
	localparam int CHAR_W = 8;
	localparam int CODE_W = 10;

	// Host bus
	localparam int WB_DW = 16;

	// K28.5, sent whenever nothing is pending
	localparam logic [CHAR_W-1:0] COMMA_BYTE = 8'hBC;

	// Refused control character counter, saturating
	localparam int ERR_CNT_W = 8;

	// Register map
	// REG_CHAR write: bit 8 = K, bits 7:0 = character
	// REG_STATUS read: bit 9 = buffer full, bit 8 = RD, bits 7:0 = refused count
	typedef enum logic
	{
		REG_CHAR   = 1'b0,
		REG_STATUS = 1'b1
	} reg_addr_e;

	// Wishbone port FSM
	typedef enum logic [1:0]
	{
		PORT_IDLE,
		PORT_WAIT,
		PORT_ACK,
		PORT_ERR
	} port_state_e;

endpackage

// ==== source/line_encoder_top.sv ====
//--------------------------------------------------------------------------
// sym_ready is the serializer's slot strobe; one code group per high edge
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module line_encoder_top
(
	input  logic                            clk,
	input  logic                            nreset,
	input  logic                            wb_cyc,
	input  logic                            wb_stb,
	input  logic                            wb_we,
	input  logic                            wb_adr,
	input  logic [line_code_pkg::WB_DW-1:0] wb_dat_w,
	output logic [line_code_pkg::WB_DW-1:0] wb_dat_r,
	output logic                            wb_ack,
	output logic                            wb_err,
	input  logic                            sym_ready,
	output logic [line_code_pkg::CODE_W-1:0] code_group,
	output logic                            rd_out
);

	logic [line_code_pkg::CHAR_W-1:0] char_data;
	logic                             char_k;
	logic                             y_is7;
	logic [5:0]                       code6_neg;
	logic                             neutral6;
	logic                             alt_neg_hint;
	logic                             alt_pos_hint;
	logic [3:0]                       code4_neg;
	logic [3:0]                       code4_alt_neg;
	logic                             neutral4;

	// HGF all ones, taken straight off the character
	assign y_is7 = (char_data[7:5] == 3'b111);

	wb_symbol_port u_port
	(
		.clk       (clk),
		.nreset    (nreset),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_dat_w  (wb_dat_w),
		.wb_dat_r  (wb_dat_r),
		.wb_ack    (wb_ack),
		.wb_err    (wb_err),
		.sym_ready (sym_ready),
		.rd_out    (rd_out),
		.char_data (char_data),
		.char_k    (char_k)
	);

	enc_5b6b u_enc6
	(
		.k            (char_k),
		.x5           (char_data[4:0]),
		.code6_neg    (code6_neg),
		.neutral6     (neutral6),
		.alt_neg_hint (alt_neg_hint),
		.alt_pos_hint (alt_pos_hint)
	);

	enc_3b4b u_enc4
	(
		.k             (char_k),
		.y3            (char_data[7:5]),
		.code4_neg     (code4_neg),
		.code4_alt_neg (code4_alt_neg),
		.neutral4      (neutral4)
	);

	disparity_merge u_merge
	(
		.clk           (clk),
		.nreset        (nreset),
		.advance       (sym_ready),
		.k             (char_k),
		.y_is7         (y_is7),
		.code6_neg     (code6_neg),
		.neutral6      (neutral6),
		.alt_neg_hint  (alt_neg_hint),
		.alt_pos_hint  (alt_pos_hint),
		.code4_neg     (code4_neg),
		.code4_alt_neg (code4_alt_neg),
		.neutral4      (neutral4),
		.code_group    (code_group),
		.rd_out        (rd_out)
	);

endmodule

// ==== source/wb_symbol_port.sv ====
//--------------------------------------------------------------------------
// Classic cycles only, one request at a time; illegal K writes end in err
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module wb_symbol_port
(
	input  logic                             clk,
	input  logic                             nreset,
	input  logic                             wb_cyc,
	input  logic                             wb_stb,
	input  logic                             wb_we,
	input  logic                             wb_adr,
	input  logic [line_code_pkg::WB_DW-1:0]  wb_dat_w,
	output logic [line_code_pkg::WB_DW-1:0]  wb_dat_r,
	output logic                             wb_ack,
	output logic                             wb_err,
	input  logic                             sym_ready,
	input  logic                             rd_out,
	output logic [line_code_pkg::CHAR_W-1:0] char_data,
	output logic                             char_k
);

	line_code_pkg::port_state_e state;
	line_code_pkg::port_state_e state_next;

	logic                                req;
	logic                                wr_char;
	logic [4:0]                          wx;
	logic [2:0]                          wy;
	logic                                k_legal;
	logic                                refuse;
	logic                                load;
	logic                                buf_full;
	logic [line_code_pkg::CHAR_W-1:0]    buf_data;
	logic                                buf_k;
	logic [line_code_pkg::ERR_CNT_W-1:0] err_cnt;

	assign req     = wb_cyc && wb_stb;
	assign wr_char = wb_we && (wb_adr == line_code_pkg::REG_CHAR);
	assign wx      = wb_dat_w[4:0];
	assign wy      = wb_dat_w[7:5];

	// K28.y, or K23/27/29/30 with y = 7
	assign k_legal = !wb_dat_w[8] || (wx == 5'd28) || ((wy == 3'd7) &&
		((wx == 5'd23) || (wx == 5'd27) || (wx == 5'd29) || (wx == 5'd30)));
	assign refuse  = (state == line_code_pkg::PORT_IDLE) && req && wr_char && !k_legal;

	always_comb
	begin
		state_next = state;
		load       = 1'b0;
		case (state)
			line_code_pkg::PORT_IDLE:
			begin
				if (req)
				begin
					if (!wr_char)
						state_next = line_code_pkg::PORT_ACK;
					else if (!k_legal)
						state_next = line_code_pkg::PORT_ERR;
					else if (!buf_full || sym_ready)
					begin
						load       = 1'b1;
						state_next = line_code_pkg::PORT_ACK;
					end
					else
						state_next = line_code_pkg::PORT_WAIT;
				end
			end
			// Buffer frees on the next sym_ready edge
			line_code_pkg::PORT_WAIT:
			begin
				if (sym_ready)
				begin
					load       = 1'b1;
					state_next = line_code_pkg::PORT_ACK;
				end
			end
			default: state_next = line_code_pkg::PORT_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge nreset)
	begin
		if (!nreset)
		begin
			state    <= line_code_pkg::PORT_IDLE;
			buf_full <= 1'b0;
			err_cnt  <= '0;
		end
		else
		begin
			state <= state_next;
			if (load)
				buf_full <= 1'b1;
			else if (sym_ready)
				buf_full <= 1'b0;
			if (refuse && (err_cnt != '1))
				err_cnt <= err_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (load)
		begin
			buf_data <= wb_dat_w[7:0];
			buf_k    <= wb_dat_w[8];
		end
	end

	// Comma fills every empty slot
	assign char_data = buf_full ? buf_data : line_code_pkg::COMMA_BYTE;
	assign char_k    = buf_full ? buf_k : 1'b1;

	assign wb_ack   = (state == line_code_pkg::PORT_ACK);
	assign wb_err   = (state == line_code_pkg::PORT_ERR);
	assign wb_dat_r = wb_ack ? {{(line_code_pkg::WB_DW - line_code_pkg::ERR_CNT_W - 2){1'b0}},
		buf_full, rd_out, err_cnt} : '0;

endmodule

// ==== tb/tb_clock.sv ====
//--------------------------------------------------------------------------
// 8 ns clock; nreset released on a falling edge after 5 cycles
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module tb_clock
(
	output logic clk,
	output logic nreset
);

	initial
	begin
		clk = 1'b0;
		forever
			#4 clk = ~clk;
	end

	// Release away from the rising edge
	initial
	begin
		nreset = 1'b0;
		repeat (5)
			@(posedge clk);
		@(negedge clk);
		nreset = 1'b1;
	end

endmodule

// ==== tb/tb_line_encoder.sv ====
//--------------------------------------------------------------------------
// Directed tests with a line monitor; expected groups come from 8b/10b tables
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module tb_line_encoder;

	localparam int bus_timeout = 200;

	// Standard RD-minus columns with a and f in the MSB
	localparam logic [5:0] six_neg_tab [0:31] = '{
		6'b100111, 6'b011101, 6'b101101, 6'b110001,
		6'b110101, 6'b101001, 6'b011001, 6'b111000,
		6'b111001, 6'b100101, 6'b010101, 6'b110100,
		6'b001101, 6'b101100, 6'b011100, 6'b010111,
		6'b011011, 6'b100011, 6'b010011, 6'b110010,
		6'b001011, 6'b101010, 6'b011010, 6'b111010,
		6'b110011, 6'b100110, 6'b010110, 6'b110110,
		6'b001110, 6'b101110, 6'b011110, 6'b101011};
	localparam logic [3:0] four_d_tab [0:7] = '{
		4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110};
	localparam logic [3:0] four_k_tab [0:7] = '{
		4'b1011, 4'b0110, 4'b1010, 4'b1100, 4'b1101, 4'b0101, 4'b1001, 4'b0111};

	logic        clk;
	logic        nreset;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic        wb_adr;
	logic [15:0] wb_dat_w;
	logic [15:0] wb_dat_r;
	logic        wb_ack;
	logic        wb_err;
	logic        sym_ready;
	logic [9:0]  code_group;
	logic        rd_out;

	int          err_cnt;
	int          timeout_cnt;
	int          wr_cnt;
	int          sent_cnt;
	int          ones;
	logic        stream_done;
	logic        model_full;
	logic        model_k;
	logic [7:0]  model_ch;
	logic        model_rd;
	logic        prev_ready;
	logic [9:0]  last_code;
	logic [10:0] exp_slot;

	tb_clock u_clock
	(
		.clk    (clk),
		.nreset (nreset)
	);

	line_encoder_top dut
	(
		.clk        (clk),
		.nreset     (nreset),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_we      (wb_we),
		.wb_adr     (wb_adr),
		.wb_dat_w   (wb_dat_w),
		.wb_dat_r   (wb_dat_r),
		.wb_ack     (wb_ack),
		.wb_err     (wb_err),
		.sym_ready  (sym_ready),
		.code_group (code_group),
		.rd_out     (rd_out)
	);

	//----------------------------------------------------------------------
	// Reference encoder returning {rd after, abcdei, fghj}
	//----------------------------------------------------------------------
	function automatic logic [10:0] encode_ref(input logic k, input logic [7:0] ch,
		input logic rd_in);
		logic [5:0] six;
		logic [3:0] four;
		logic       rd_mid;
		logic       rd_end;
		logic [4:0] x;
		logic [2:0] y;
		logic       a7;
		x = ch[4:0];
		y = ch[7:5];
		six = (k && (x == 5'd28)) ? 6'b001111 : six_neg_tab[x];
		// Only balanced codes other than D.07 have a single form
		if (rd_in && !(($countones(six) == 3) && (x != 5'd7)))
			six = ~six;
		rd_mid = ($countones(six) > 3) ? 1'b1 : (($countones(six) < 3) ? 1'b0 : rd_in);
		a7 = (y == 3'd7) && (rd_mid ? ((x == 5'd11) || (x == 5'd13) || (x == 5'd14))
			: ((x == 5'd17) || (x == 5'd18) || (x == 5'd20)));
		if (k)
			four = four_k_tab[y];
		else if (a7)
			four = 4'b0111;
		else
			four = four_d_tab[y];
		if (rd_mid && !(!k && !a7 && ((y == 3'd1) || (y == 3'd2) || (y == 3'd5) || (y == 3'd6))))
			four = ~four;
		rd_end = ($countones(four) > 2) ? 1'b1 : (($countones(four) < 2) ? 1'b0 : rd_mid);
		return {rd_end, six, four};
	endfunction

	task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp)
		begin
			err_cnt++;
			$display("ERR @%0t ns: %s, got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic finish_run();
		$display("Checks failed: %0d, timeouts: %0d", err_cnt, timeout_cnt);
		if ((err_cnt == 0) && (timeout_cnt == 0))
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	endtask

	task automatic abort_run(input string why);
		timeout_cnt++;
		$display("%s", why);
		finish_run();
	endtask

	//----------------------------------------------------------------------
	// Line monitor with one slot per sym_ready edge
	//----------------------------------------------------------------------
	always @(negedge clk)
	begin
		if (!nreset)
		begin
			model_full = 1'b0;
			model_rd   = 1'b0;
			prev_ready = 1'b0;
			last_code  = '0;
		end
		else
		begin
			if (prev_ready)
			begin
				exp_slot = model_full ? encode_ref(model_k, model_ch, model_rd)
					: encode_ref(1'b1, line_code_pkg::COMMA_BYTE, model_rd);
				ones = $countones(code_group);
				check_equal(code_group, exp_slot[9:0], "code group on the line");
				check_equal(rd_out, exp_slot[10], "running disparity after slot");
				check_equal((ones >= 4) && (ones <= 6), 1'b1, "code group weight");
				model_rd  = exp_slot[10];
				last_code = exp_slot[9:0];
				if (model_full)
					sent_cnt++;
				model_full = 1'b0;
			end
			else
			begin
				check_equal(code_group, last_code, "code group held without sym_ready");
				check_equal(rd_out, model_rd, "disparity held without sym_ready");
			end
			// Ack of a character write means it was taken into the buffer
			if (wb_ack && wb_we && (wb_adr == line_code_pkg::REG_CHAR))
			begin
				model_full = 1'b1;
				model_k    = wb_dat_w[8];
				model_ch   = wb_dat_w[7:0];
				wr_cnt++;
			end
			prev_ready = sym_ready;
		end
	end

	//----------------------------------------------------------------------
	// Wishbone master
	//----------------------------------------------------------------------
	task automatic wait_ack(output logic got_err, output logic [15:0] data);
		int n;
		n = 0;
		do
		begin
			@(negedge clk);
			n++;
		end
		while (!(wb_ack || wb_err) && (n < bus_timeout));
		got_err = wb_err;
		data    = wb_dat_r;
		if (!(wb_ack || wb_err))
			abort_run("Timeout: the Wishbone request got neither ack nor err");
	endtask

	task automatic end_cycle();
		@(posedge clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
	endtask

	task automatic wb_write(input logic k, input logic [7:0] ch, output logic got_err);
		logic [15:0] rdata;
		@(posedge clk);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= 1'b1;
		wb_adr   <= line_code_pkg::REG_CHAR;
		wb_dat_w <= {7'b0, k, ch};
		wait_ack(got_err, rdata);
		end_cycle();
	endtask

	task automatic wb_read(input logic addr, output logic [15:0] data);
		logic e;
		@(posedge clk);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we  <= 1'b0;
		wb_adr <= addr;
		wait_ack(e, data);
		check_equal(e, 1'b0, "err on status read");
		end_cycle();
	endtask

	// Write with sym_ready low, then one slot for that character only
	task automatic send_one(input logic k, input logic [7:0] ch, output logic rd_before);
		logic e;
		wb_write(k, ch, e);
		check_equal(e, 1'b0, $sformatf("err on legal write of %02h", ch));
		rd_before = model_rd;
		sym_ready <= 1'b1;
		@(posedge clk);
		sym_ready <= 1'b0;
		@(negedge clk);
	endtask

	task automatic send_expect(input logic k, input logic [7:0] ch, input logic [9:0] exp_neg,
		input logic [9:0] exp_pos);
		logic rdb;
		send_one(k, ch, rdb);
		check_equal(code_group, rdb ? exp_pos : exp_neg, $sformatf("code group of %02h", ch));
	endtask

	// Let the buffer empty onto the line, then stop the slots
	task automatic drain();
		int n;
		n = 0;
		sym_ready <= 1'b1;
		do
		begin
			@(posedge clk);
			n++;
		end
		while (model_full && (n < 50));
		if (model_full)
			abort_run("Timeout: the buffered character never left");
		else
			sym_ready <= 1'b0;
	endtask

	//----------------------------------------------------------------------
	// Tests
	//----------------------------------------------------------------------
	task automatic test_idle();
		logic exp_rd;
		exp_rd = 1'b0;
		check_equal(rd_out, 1'b0, "disparity after reset");
		sym_ready <= 1'b1;
		repeat (6)
		begin
			@(posedge clk);
			@(negedge clk);
			check_equal(code_group, exp_rd ? 10'b1100000101 : 10'b0011111010, "idle comma");
			exp_rd = ~exp_rd;
		end
		@(posedge clk);
		sym_ready <= 1'b0;
	endtask

	task automatic test_known_codes();
		send_expect(1'b0, 8'h00, 10'b1001110100, 10'b0110001011);
		send_expect(1'b0, 8'hB5, 10'b1010101010, 10'b1010101010);
		send_expect(1'b0, 8'h07, 10'b1110001011, 10'b0001110100);
		send_expect(1'b0, 8'hE7, 10'b1110001110, 10'b0001110001);
	endtask

	task automatic test_controls();
		int   y;
		logic rdb;
		for (y = 0; y < 8; y++)
			send_one(1'b1, {y[2:0], 5'd28}, rdb);
		send_one(1'b1, 8'hF7, rdb);
		send_one(1'b1, 8'hFB, rdb);
		send_one(1'b1, 8'hFD, rdb);
		send_one(1'b1, 8'hFE, rdb);
		// Each round starts on the other disparity
		repeat (2)
		begin
			send_expect(1'b0, 8'hF1, 10'b1000110111, 10'b1000110001);
			send_expect(1'b0, 8'hEB, 10'b1101001110, 10'b1101001000);
			send_one(1'b1, line_code_pkg::COMMA_BYTE, rdb);
		end
	endtask

	task automatic test_illegal_k();
		logic        e;
		logic [15:0] s0;
		logic [15:0] s1;
		wb_read(line_code_pkg::REG_STATUS, s0);
		wb_write(1'b1, 8'h00, e);
		check_equal(e, 1'b1, "K0.0 refused");
		wb_write(1'b1, 8'hB5, e);
		check_equal(e, 1'b1, "K21.5 refused");
		wb_read(line_code_pkg::REG_STATUS, s1);
		check_equal(s1[7:0], s0[7:0] + 8'd2, "refused count");
		check_equal(s1[9], 1'b0, "buffer empty after refused writes");
		check_equal(s1[8], model_rd, "status disparity bit");
	endtask

	task automatic test_random_stream();
		int          i;
		logic        e;
		logic [31:0] rnd;
		sym_ready <= 1'b1;
		for (i = 0; i < 200; i++)
		begin
			rnd = $urandom;
			wb_write(1'b0, rnd[7:0], e);
			check_equal(e, 1'b0, "err on random data write");
		end
		drain();
	endtask

	task automatic test_backpressure();
		int          i;
		int          n;
		logic        e;
		logic [15:0] d;
		logic [31:0] r_wr;
		logic [31:0] r_rdy;
		wb_write(1'b0, 8'h4A, e);
		// Buffer is now full, so this write must wait
		@(posedge clk);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= 1'b1;
		wb_adr   <= line_code_pkg::REG_CHAR;
		wb_dat_w <= 16'h0055;
		repeat (6)
		begin
			@(negedge clk);
			check_equal(wb_ack, 1'b0, "ack while buffer full");
		end
		@(posedge clk);
		sym_ready <= 1'b1;
		@(posedge clk);
		sym_ready <= 1'b0;
		wait_ack(e, d);
		check_equal(e, 1'b0, "err on delayed write");
		end_cycle();

		stream_done = 1'b0;
		fork
			begin
				for (i = 0; i < 40; i++)
				begin
					r_wr = $urandom;
					wb_write(1'b0, r_wr[7:0], e);
					check_equal(e, 1'b0, "err on write under back-pressure");
				end
				stream_done = 1'b1;
			end
			begin
				n = 0;
				while (!stream_done && (n < 20000))
				begin
					@(posedge clk);
					r_rdy = $urandom;
					sym_ready <= r_rdy[0];
					n++;
				end
			end
		join
		drain();
	endtask

	initial
	begin
		int          n;
		logic [15:0] st;
		wb_cyc      = 1'b0;
		wb_stb      = 1'b0;
		wb_we       = 1'b0;
		wb_adr      = 1'b0;
		wb_dat_w    = '0;
		sym_ready   = 1'b0;
		err_cnt     = 0;
		timeout_cnt = 0;
		wr_cnt      = 0;
		sent_cnt    = 0;
		stream_done = 1'b0;
		void'($urandom(32'h7f104226));

		n = 0;
		while ((nreset !== 1'b1) && (n < 20))
		begin
			@(posedge clk);
			n++;
		end
		if (nreset !== 1'b1)
			abort_run("Timeout: reset was never released");
		else
		begin
			test_idle();
			test_known_codes();
			test_controls();
			test_illegal_k();
			test_random_stream();
			test_backpressure();

			// Nothing lost or duplicated overall
			check_equal(sent_cnt, wr_cnt, "characters sent against characters written");
			wb_read(line_code_pkg::REG_STATUS, st);
			check_equal(st[9], 1'b0, "buffer empty at the end");
			finish_run();
		end
	end

endmodule
